// File: tcb_logsize_mem.f
hw/tcb_pkg.sv
hw/tcb_req_delay.sv
hw/tcb_logsize2byteena.sv
hw/tcb_byteena_mem.sv
hw/tcb_logsize_mem.sv
verif/tcb_logsize_mem_tb.sv

// File: verif/tcb_logsize_mem_tb.sv
/* testbench for the TCB log-size memory path, drives requests on the falling
   edge and compares every response against a shadow byte memory model */

`default_nettype none

module tcb_logsize_mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import tcb_pkg::*;

  localparam int unsigned DLY       = 1;
  localparam int unsigned MEM_WORDS = 64;
  // cycles any wait may take
  localparam int unsigned WAIT_MAX  = 100;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic     clk = 1'b0;
  logic     arst_n;
  logic     vld;
  logic     wen;
  tcb_adr_t adr;
  tcb_siz_t siz;
  logic     ndn;
  tcb_dat_t wdt;
  logic     rsp_vld;
  tcb_dat_t rdt;
  logic     sts;

  tcb_logsize_mem #(
    .DLY       (DLY),
    .ALIGNED   (1'b0),
    .MEM_WORDS (MEM_WORDS)
  ) uut (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .ndn     (ndn),
    .wdt     (wdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // rising edge count, used for latency
  int unsigned cyc = 0;
  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////
  // reference model and bookkeeping
  ////////////////////////////////////////

  // one entry per byte of the memory
  logic [7:0] shadow [MEM_WORDS*4];

  // expected {sts, rdt} and due cycle, in request order
  logic [32:0] exp_q [$];
  int unsigned due_q [$];

  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned tests  = 0;
  int unsigned err_at_start;

  // byte k lives in lane off+k (little) or off-k (big), mod 4
  function automatic logic [32:0] predict_rsp(input logic w, input tcb_adr_t a,
                                              input tcb_siz_t s, input logic n,
                                              input tcb_dat_t d);
    int unsigned wrd;
    int unsigned off;
    int unsigned lane;
    logic [31:0] r;
    wrd = a >> 2;
    off = a % 4;
    r   = '0;
    // beyond the depth: error, nothing stored
    if (wrd >= MEM_WORDS) return {1'b1, 32'h0};
    for (int unsigned k = 0; k < (1 << s); k++) begin
      lane = (n == TCB_LITTLE) ? (off + k) % 4 : (off + 4 - k) % 4;
      if (w) shadow[wrd*4 + lane] = d[8*k +: 8];
      else r[8*k +: 8] = shadow[wrd*4 + lane];
    end
    // writes answer with zero data
    return {1'b0, r};
  endfunction

  // preload value, spread over the full address
  function automatic tcb_dat_t fill_word(input tcb_adr_t a);
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h3c5a_0f96;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0.1f ns: %s got %h expected %h", $realtime, msg, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // one request per call, one cycle each
  task automatic issue(input logic w, input tcb_adr_t a, input tcb_siz_t s,
                       input logic n, input tcb_dat_t d);
    @(negedge clk);
    vld = 1'b1;
    wen = w;
    adr = a;
    siz = s;
    ndn = n;
    wdt = d;
    exp_q.push_back(predict_rsp(w, a, s, n, d));
    due_q.push_back(cyc + DLY);
  endtask

  // bus idle, then wait until every response is back
  task automatic drain(input string what);
    int unsigned n;
    @(negedge clk);
    vld = 1'b0;
    wen = 1'b0;
    n   = 0;
    while (exp_q.size() != 0 && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d responses never came back during %s", exp_q.size(), what);
      $display("Test failed");
      $finish;
    end
  endtask

  task automatic start_test();
    err_at_start = errors;
    tests++;
  endtask

  task automatic report_test(input string name);
    if (errors == err_at_start) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, errors - err_at_start);
  endtask

  ////////////////////////////////////////
  // response compare
  ////////////////////////////////////////

  // outputs are registered, stable at the falling edge
  always @(negedge clk) begin : compare
    logic [32:0] exp_v;
    int unsigned due_v;
    if (arst_n && rsp_vld) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("response at %0.1f ns with no request outstanding", $realtime);
      end else begin
        exp_v = exp_q.pop_front();
        due_v = due_q.pop_front();
        check(rdt, exp_v[31:0], "rdt");
        check(sts, exp_v[32], "sts");
        check(cyc, due_v, "response cycle");
      end
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin : run
    tcb_adr_t    a;
    void'($urandom(32'h8385));
    arst_n = 1'b0;
    vld    = 1'b0;
    wen    = 1'b0;
    adr    = '0;
    siz    = TCB_BYTE;
    ndn    = TCB_LITTLE;
    wdt    = '0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;

    // no response without a request
    start_test();
    repeat (4) begin
      @(negedge clk);
      check(rsp_vld, 1'b0, "rsp_vld after reset");
    end
    report_test("reset");

    // memory is not reset, preload every word
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      issue(1'b1, i*4, TCB_WORD, TCB_LITTLE, fill_word(i*4));
    end
    drain("preload");

    // every size at every offset, little endian
    start_test();
    for (int unsigned s = 0; s < 3; s++) begin
      for (int unsigned o = 0; o < 4; o++) begin
        a = (8 + s*4 + o)*4 + o;
        issue(1'b1, a, tcb_siz_t'(s), TCB_LITTLE, $urandom);
        issue(1'b0, a, tcb_siz_t'(s), TCB_LITTLE, '0);
      end
    end
    drain("little endian sweep");
    report_test("little endian sizes and offsets");

    // big endian half at offset 0, byte 1 wraps to lane 3
    start_test();
    issue(1'b1, 5*4, TCB_HALF, TCB_BIG, 32'h0000_beef);
    issue(1'b0, 5*4, TCB_WORD, TCB_LITTLE, '0);
    issue(1'b0, 5*4 + 3, TCB_BYTE, TCB_LITTLE, '0);
    drain("big endian wrap");
    report_test("big endian wrap-around");

    // random traffic, no idle cycles
    start_test();
    for (int unsigned i = 0; i < 200; i++) begin
      a = ($urandom % (MEM_WORDS + 8))*4 + ($urandom % 4);
      issue(1'(($urandom % 2)), a, tcb_siz_t'($urandom % 3), 1'(($urandom % 2)), $urandom);
    end
    drain("random traffic");
    report_test("back-to-back pipelining");

    // word 64 aliases word 0 in the array, must stay untouched
    start_test();
    issue(1'b1, MEM_WORDS*4, TCB_WORD, TCB_LITTLE, 32'hdead_c0de);
    issue(1'b0, MEM_WORDS*4, TCB_WORD, TCB_LITTLE, '0);
    issue(1'b0, 32'h8000_0006, TCB_HALF, TCB_BIG, '0);
    issue(1'b0, 0, TCB_WORD, TCB_LITTLE, '0);
    drain("out of range");
    report_test("out of range");

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/tcb_logsize_mem.sv
/* top level of the TCB log-size memory path, converter plus byte enable
   memory with a request delay line, sets latency, mode and depth */

`default_nettype none

module tcb_logsize_mem #(
  parameter int unsigned DLY       = 1,
  parameter bit          ALIGNED   = 1'b0,
  parameter int unsigned MEM_WORDS = 64
)(
  input  wire                    clk,
  input  wire                    arst_n,
  // manager request
  input  wire                    vld,
  input  wire                    wen,
  input  wire tcb_pkg::tcb_adr_t adr,
  input  wire tcb_pkg::tcb_siz_t siz,
  input  wire                    ndn,
  input  wire tcb_pkg::tcb_dat_t wdt,
  // manager response
  output logic                   rsp_vld,
  output tcb_pkg::tcb_dat_t      rdt,
  output logic                   sts
);

  import tcb_pkg::*;

  // byte enable bus between converter and memory
  logic     mem_vld;
  logic     mem_wen;
  tcb_adr_t mem_adr;
  tcb_ben_t mem_ben;
  tcb_dat_t mem_wdt;
  tcb_dat_t mem_rdt;

  // delayed request attributes
  tcb_siz_t dly_siz;
  tcb_off_t dly_off;
  logic     dly_ndn;

  ////////////////////////////////////////
  // submodules
  ////////////////////////////////////////

  tcb_req_delay #(
    .DLY     (DLY)
  ) u_dly (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .siz     (siz),
    .off     (adr[TCB_OFF_W-1:0]),
    .ndn     (ndn),
    .dly_siz (dly_siz),
    .dly_off (dly_off),
    .dly_ndn (dly_ndn)
  );

  tcb_logsize2byteena #(
    .ALIGNED (ALIGNED)
  ) u_cnv (
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .ndn     (ndn),
    .wdt     (wdt),
    .man_vld (mem_vld),
    .man_wen (mem_wen),
    .man_adr (mem_adr),
    .man_ben (mem_ben),
    .man_wdt (mem_wdt),
    .man_rdt (mem_rdt),
    .dly_siz (dly_siz),
    .dly_off (dly_off),
    .dly_ndn (dly_ndn),
    .rdt     (rdt)
  );

  // status goes straight back to the manager
  tcb_byteena_mem #(
    .DLY       (DLY),
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (mem_vld),
    .wen     (mem_wen),
    .adr     (mem_adr),
    .ben     (mem_ben),
    .wdt     (mem_wdt),
    .rsp_vld (rsp_vld),
    .rdt     (mem_rdt),
    .sts     (sts)
  );

endmodule

`default_nettype wire

// File: hw/tcb_byteena_mem.sv
/* TCB byte enable memory subordinate, never stalls, read data and status
   return DLY cycles after the request */

`default_nettype none

module tcb_byteena_mem #(
  parameter int unsigned DLY       = 1,
  parameter int unsigned MEM_WORDS = 64
)(
  input  wire                    clk,
  input  wire                    arst_n,
  // request
  input  wire                    vld,
  input  wire                    wen,
  input  wire tcb_pkg::tcb_adr_t adr,
  input  wire tcb_pkg::tcb_ben_t ben,
  input  wire tcb_pkg::tcb_dat_t wdt,
  // response
  output logic                   rsp_vld,
  output tcb_pkg::tcb_dat_t      rdt,
  output logic                   sts
);

  import tcb_pkg::*;

  // word index bits
  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // storage
  tcb_dat_t mem [MEM_WORDS];

  // word index and range check
  logic [TCB_ADR_W-TCB_OFF_W-1:0] wrd;
  logic [IDX_W-1:0]               idx;
  logic                           in_rng;

  // response pipeline
  logic     [DLY-1:0] vld_q;
  logic     [DLY-1:0] sts_q;
  tcb_dat_t [DLY-1:0] rdt_q;

  assign wrd    = adr[TCB_ADR_W-1:TCB_OFF_W];
  assign idx    = wrd[IDX_W-1:0];
  assign in_rng = (wrd < MEM_WORDS);

  ////////////////////////////////////////
  // write
  ////////////////////////////////////////

  // enabled lanes only, out of range writes dropped
  always_ff @(posedge clk) begin
    if (vld && wen && in_rng) begin
      for (int unsigned i = 0; i < TCB_BEN; i++) begin
        if (ben[i]) begin
          mem[idx][i*TCB_UNT +: TCB_UNT] <= wdt[i*TCB_UNT +: TCB_UNT];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read and response
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
      sts_q <= '0;
    end else begin
      vld_q[0] <= vld;
      // error for any access past the end
      sts_q[0] <= vld & ~in_rng;
      for (int unsigned i = 1; i < DLY; i++) begin
        vld_q[i] <= vld_q[i-1];
        sts_q[i] <= sts_q[i-1];
      end
    end
  end

  // read data, zero for writes and out of range
  always_ff @(posedge clk) begin
    rdt_q[0] <= (vld && !wen && in_rng) ? mem[idx] : '0;
    for (int unsigned i = 1; i < DLY; i++) begin
      rdt_q[i] <= rdt_q[i-1];
    end
  end

  assign rsp_vld = vld_q[DLY-1];
  assign sts     = sts_q[DLY-1];
  assign rdt     = rdt_q[DLY-1];

endmodule

`default_nettype wire

// File: hw/tcb_logsize2byteena.sv
/* TCB converter from logarithmic size mode to byte enable mode, places write
   bytes into lanes and re-packs read lanes into the low bytes of rdt */

`default_nettype none

module tcb_logsize2byteena #(
  parameter bit ALIGNED = 1'b0
)(
  // manager side request
  input  wire                    vld,
  input  wire                    wen,
  input  wire tcb_pkg::tcb_adr_t adr,
  input  wire tcb_pkg::tcb_siz_t siz,
  input  wire                    ndn,
  input  wire tcb_pkg::tcb_dat_t wdt,
  // memory side request
  output logic                   man_vld,
  output logic                   man_wen,
  output tcb_pkg::tcb_adr_t      man_adr,
  output tcb_pkg::tcb_ben_t      man_ben,
  output tcb_pkg::tcb_dat_t      man_wdt,
  // response
  input  wire tcb_pkg::tcb_dat_t man_rdt,
  input  wire tcb_pkg::tcb_siz_t dly_siz,
  input  wire tcb_pkg::tcb_off_t dly_off,
  input  wire                    dly_ndn,
  output tcb_pkg::tcb_dat_t      rdt
);

  import tcb_pkg::*;

  // byte lane views of the data buses
  logic [TCB_BEN-1:0][TCB_UNT-1:0] req_wdt;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] lane_wdt;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] lane_rdt;
  logic [TCB_BEN-1:0][TCB_UNT-1:0] rsp_rdt;

  // request offset and log-size masks
  tcb_off_t req_off;
  tcb_ben_t req_msk;
  tcb_ben_t rsp_msk;

  // low 2**s lanes set
  function automatic tcb_ben_t siz_mask(input tcb_siz_t s);
    tcb_ben_t m;
    for (int unsigned i = 0; i < TCB_BEN; i++) begin
      m[i] = (i < (1 << s));
    end
    return m;
  endfunction

  ////////////////////////////////////////
  // request
  ////////////////////////////////////////

  // handshake and command pass straight on
  assign man_vld = vld;
  assign man_wen = wen;

  // word aligned address to the memory
  assign man_adr = {adr[TCB_ADR_W-1:TCB_OFF_W], TCB_OFF_W'(0)};
  assign req_off = adr[TCB_OFF_W-1:0];

  assign req_msk = siz_mask(siz);
  assign req_wdt = wdt;
  assign man_wdt = lane_wdt;

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  assign rsp_msk  = siz_mask(dly_siz);
  assign lane_rdt = man_rdt;

  // bytes above the access size read as zero
  always_comb begin
    for (int unsigned i = 0; i < TCB_BEN; i++) begin
      rdt[i*TCB_UNT +: TCB_UNT] = rsp_msk[i] ? rsp_rdt[i] : '0;
    end
  end

  ////////////////////////////////////////
  // lane multiplexers
  ////////////////////////////////////////

  if (ALIGNED) begin : g_aligned

    // offset aligned down to the access size
    tcb_off_t aln_off;

    always_comb begin
      case (siz)
        TCB_BYTE: aln_off = req_off;
        TCB_HALF: aln_off = {req_off[1], 1'b0};
        default:  aln_off = '0;
      endcase
    end

    assign man_ben = req_msk << aln_off;

    // write lanes, endianness ignored
    always_comb begin
      lane_wdt = '0;
      case (siz)
        TCB_BYTE: lane_wdt[req_off] = req_wdt[0];
        TCB_HALF: begin
          if (req_off[1]) begin
            lane_wdt[3] = req_wdt[1];
            lane_wdt[2] = req_wdt[0];
          end else begin
            lane_wdt[1] = req_wdt[1];
            lane_wdt[0] = req_wdt[0];
          end
        end
        TCB_WORD: lane_wdt = req_wdt;
        default:  lane_wdt = '0;
      endcase
    end

    // read lanes back into the low bytes
    always_comb begin
      rsp_rdt = '0;
      case (dly_siz)
        TCB_BYTE: rsp_rdt[0] = lane_rdt[dly_off];
        TCB_HALF: begin
          if (dly_off[1]) begin
            rsp_rdt[1] = lane_rdt[3];
            rsp_rdt[0] = lane_rdt[2];
          end else begin
            rsp_rdt[1] = lane_rdt[1];
            rsp_rdt[0] = lane_rdt[0];
          end
        end
        TCB_WORD: rsp_rdt = lane_rdt;
        default:  rsp_rdt = '0;
      endcase
    end

  end else begin : g_rotate

    // little: byte k to lane off+k, big: byte k to lane off-k, mod 4
    always_comb begin
      for (int unsigned i = 0; i < TCB_BEN; i++) begin
        if (ndn == TCB_LITTLE) begin
          man_ben[i]  = req_msk[tcb_off_t'(i - req_off)];
          lane_wdt[i] = req_wdt[tcb_off_t'(i - req_off)];
        end else begin
          man_ben[i]  = req_msk[tcb_off_t'(req_off - i)];
          lane_wdt[i] = req_wdt[tcb_off_t'(req_off - i)];
        end
      end
    end

    // inverse rotation, byte k from the lane it was written to
    always_comb begin
      for (int unsigned i = 0; i < TCB_BEN; i++) begin
        if (dly_ndn == TCB_LITTLE) begin
          rsp_rdt[i] = lane_rdt[tcb_off_t'(dly_off + i)];
        end else begin
          rsp_rdt[i] = lane_rdt[tcb_off_t'(dly_off - i)];
        end
      end
    end

  end

endmodule

`default_nettype wire

// File: hw/tcb_req_delay.sv
/* request attribute delay line, keeps size, offset and endianness of each
   request in flight until its response returns DLY cycles later */

`default_nettype none

module tcb_req_delay #(
  parameter int unsigned DLY = 1
)(
  input  wire                    clk,
  input  wire                    arst_n,
  // request attributes
  input  wire                    vld,
  input  wire tcb_pkg::tcb_siz_t siz,
  input  wire tcb_pkg::tcb_off_t off,
  input  wire                    ndn,
  // attributes aligned with the response
  output tcb_pkg::tcb_siz_t      dly_siz,
  output tcb_pkg::tcb_off_t      dly_off,
  output logic                   dly_ndn
);

  import tcb_pkg::*;

  // one stage per cycle of read latency
  tcb_siz_t [DLY-1:0] siz_q;
  tcb_off_t [DLY-1:0] off_q;
  logic     [DLY-1:0] ndn_q;

  ////////////////////////////////////////
  // shift register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      siz_q <= '0;
      off_q <= '0;
      ndn_q <= '0;
    end else begin
      // first stage, capture on a transfer
      if (vld) begin
        siz_q[0] <= siz;
        off_q[0] <= off;
        ndn_q[0] <= ndn;
      end else begin
        // idle slot, keep the stage quiet
        siz_q[0] <= '0;
        off_q[0] <= '0;
        ndn_q[0] <= 1'b0;
      end
      // remaining stages shift every cycle
      for (int unsigned i = 1; i < DLY; i++) begin
        siz_q[i] <= siz_q[i-1];
        off_q[i] <= off_q[i-1];
        ndn_q[i] <= ndn_q[i-1];
      end
    end
  end

  // last stage lines up with memory rsp_vld
  assign dly_siz = siz_q[DLY-1];
  assign dly_off = off_q[DLY-1];
  assign dly_ndn = ndn_q[DLY-1];

endmodule

`default_nettype wire

// File: hw/tcb_pkg.sv
/* shared TCB bus widths, size and endianness encodings and vector typedefs
   imported by every RTL module of the log-size memory path */

`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // address and data bus widths
  localparam int unsigned TCB_ADR_W = 32;
  localparam int unsigned TCB_DAT_W = 32;

  // byte lane width and count
  localparam int unsigned TCB_UNT = 8;
  localparam int unsigned TCB_BEN = TCB_DAT_W / TCB_UNT;

  // byte offset bits within a word
  localparam int unsigned TCB_OFF_W = $clog2(TCB_BEN);

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  typedef logic [TCB_ADR_W-1:0] tcb_adr_t;
  typedef logic [TCB_DAT_W-1:0] tcb_dat_t;
  typedef logic [TCB_BEN-1:0]   tcb_ben_t;
  typedef logic [TCB_OFF_W-1:0] tcb_off_t;

  // logarithmic transfer size, 2**siz bytes
  typedef logic [1:0] tcb_siz_t;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // sizes, value 3 is illegal
  localparam tcb_siz_t TCB_BYTE = 2'd0;
  localparam tcb_siz_t TCB_HALF = 2'd1;
  localparam tcb_siz_t TCB_WORD = 2'd2;

  // endianness (ndn) bit
  localparam logic TCB_LITTLE = 1'b0;
  localparam logic TCB_BIG    = 1'b1;

endpackage

`default_nettype wire
